//--- verification/mem_patterns.txt
// kind(0 alu,1 load,2 store,3 csr) width(1 b,2 h,3 w) signed rd addr/operand store_data expected
// memory word i starts as bytes {i^80, i^40, i^20, i^10}
0_0_0_01_11112222_00000000_11112222
1_3_0_02_00000010_00000000_84442414
1_1_1_03_00000013_00000000_ffffff84
1_1_0_04_00000013_00000000_00000084
1_2_1_05_00000022_00000000_ffff8848
1_2_0_06_00000020_00000000_00002818
2_3_0_00_00000040_cafef00d_00000000
1_3_0_07_00000040_00000000_cafef00d
2_1_0_00_00000041_000000a5_00000000
1_2_1_08_00000040_00000000_ffffa50d
2_2_0_00_00000046_00001234_00000000
1_3_0_0a_00000044_00000000_12343101
1_2_0_0b_00000043_00000000_00000000
2_3_0_00_00000042_55555555_00000000
3_0_0_09_00000300_00000000_00000300
1_1_0_0c_00000045_00000000_00000031
1_1_1_0d_00000000_00000000_00000010
1_3_0_0e_000003fc_00000000_7fbfdfef
0_0_0_00_deadbeef_00000000_deadbeef
1_3_0_0f_00000040_00000000_cafea50d

//--- files.f
+incdir+design
design/frv_pkg.sv
design/frv_pipeline_register.sv
design/frv_lsu.sv
design/frv_pipeline_memory.sv
design/frv_load_response.sv
design/frv_mem_subsys.sv
verification/frv_mem_checker.sv
verification/tb_frv_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_frv_mem_subsys

out=$(./obj_dir/Vtb_frv_mem_subsys)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
else
    exit 1
fi

//--- verification/tb_frv_mem_subsys.sv
// --------------------------------------
// Testbench for the memory subsystem
// Patterns come from verification/, run
// from the project root; flush stays low
// --------------------------------------
`timescale 1ns/10ps
`include "frv_consts.svh"

module tb_frv_mem_subsys;

    import frv_pkg::*;

    localparam int NPAT = 20;

    logic         g_clk;
    logic         rst;
    logic         flush;
    logic         hold_lsu_req;
    s3_op_t       s3_op;
    logic         s3_valid;
    logic         s3_busy;
    fwd_t         fwd;
    logic         dmem_req;
    dmem_req_t    dmem;
    logic         dmem_gnt;
    logic         dmem_recv;
    logic [31:0]  dmem_rdata;
    wb_t          wb;
    logic         wb_valid;
    logic         wb_busy;
    logic [115:0] pats [0:NPAT-1];   // kind,width,sgn,rd,addr,data,exp
    logic [31:0]  mem [0:255];       // Memory model
    int           results;
    int           val_errors;
    int           proto_errors;
    int           cycle;
    int           gnt_wait;          // Cycles before next grant
    logic         pend_valid;        // Granted, not yet accepted
    logic [31:0]  pend_data;
    logic [31:0]  resp_data [$];
    int           resp_due [$];
    logic [7:0]   widx;

    frv_mem_subsys dut (.*);

    frv_mem_checker #(.NPAT(NPAT)) u_chk (.*);

    // Pattern word to s3 operation
    function automatic s3_op_t build_op(input logic [115:0] p, input int n);
        s3_op_t op;
        op       = '0;
        op.rd    = p[100:96];
        op.opr_a = p[95:64];
        op.opr_b = p[63:32];
        op.size  = 2'b11;
        op.instr = 32'(n);
        case (p[115:112])
            4'h1, 4'h2: begin
                op.fu[`FRV_FU_LSU]       = 1'b1;
                op.uop[`FRV_LSU_LOAD]    = (p[115:112] == 4'h1);
                op.uop[`FRV_LSU_STORE]   = (p[115:112] == 4'h2);
                op.uop[2:1]              = p[109:108];
                op.uop[`FRV_LSU_SIGNED]  = p[104];
            end
            4'h3:    op.fu[`FRV_FU_CSR] = 1'b1;
            default: op.fu[0]           = 1'b1;   // ALU
        endcase
        return op;
    endfunction

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // Watchdog ---------------------------
    initial begin
        #(NPAT * 40 * 4);
        $display("Timeout: only %0d of %0d results arrived", results, NPAT);
        $display("Test failures found");
        $finish;
    end

    // Stimulus ---------------------------
    initial begin
        void'($urandom(32'he5753306));
        rst          = 1'b1;
        flush        = 1'b0;
        s3_valid     = 1'b0;
        s3_op        = '0;
        hold_lsu_req = 1'b0;
        wb_busy      = 1'b0;
        dmem_gnt     = 1'b0;
        dmem_recv    = 1'b0;
        dmem_rdata   = '0;
        $readmemh("verification/mem_patterns.txt", pats);
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'h80, 8'(i) ^ 8'h40, 8'(i) ^ 8'h20, 8'(i) ^ 8'h10};
        end
        repeat (3) @(posedge g_clk);
        rst <= 1'b0;
        for (int i = 0; i < NPAT; i++) begin
            @(posedge g_clk);
            s3_op    <= build_op(pats[i], i);
            s3_valid <= 1'b1;
            do @(posedge g_clk); while (s3_busy);   // Held until accepted
            s3_valid <= 1'b0;
        end
        wait (results == NPAT);
        repeat (4) @(posedge g_clk);
        $display("Errors: %0d value, %0d protocol", val_errors, proto_errors);
        if (val_errors == 0 && proto_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Random back-pressure
    always @(posedge g_clk) begin
        if (rst) begin
            wb_busy      <= 1'b0;
            hold_lsu_req <= 1'b0;
        end else begin
            wb_busy      <= ($urandom % 4) == 0;
            hold_lsu_req <= ($urandom % 8) == 0;
        end
    end

    // Memory model -----------------------
    always @(posedge g_clk) begin
        if (rst) begin
            dmem_gnt   <= 1'b0;
            dmem_recv  <= 1'b0;
            dmem_rdata <= '0;
            gnt_wait   = 0;
            pend_valid = 1'b0;
            cycle      = 0;
        end else begin
            cycle++;
            dmem_recv <= 1'b0;
            if (dmem_req && dmem_gnt) begin
                widx = dmem.addr[9:2];
                for (int b = 0; b < 4; b++) begin
                    if (dmem.wen && dmem.strb[b]) begin
                        mem[widx][8*b +: 8] = dmem.wdata[8*b +: 8];
                    end
                end
                pend_data  = dmem.wen ? 32'h0 : mem[widx];
                pend_valid = 1'b1;
                dmem_gnt  <= 1'b0;
                gnt_wait   = int'($urandom % 4);
            end else if (dmem_req && !dmem_gnt) begin
                if (gnt_wait == 0) begin
                    dmem_gnt <= 1'b1;
                end else begin
                    gnt_wait--;
                end
            end
            // Response timed from when the op enters s4
            if (pend_valid && s3_valid && !s3_busy) begin
                resp_data.push_back(pend_data);
                resp_due.push_back(cycle + 1 + int'($urandom % 2));
                pend_valid = 1'b0;
            end
            if (resp_due.size() > 0 && cycle >= resp_due[0]) begin
                dmem_recv  <= 1'b1;
                dmem_rdata <= resp_data.pop_front();
                void'(resp_due.pop_front());
            end
        end
    end

endmodule

//--- verification/frv_mem_checker.sv
// --------------------------------------
// Scoreboard for the memory subsystem
// Results must come back in pattern order
// Pattern word layout is set by the testbench
// --------------------------------------
`timescale 1ns/10ps
`include "frv_consts.svh"

module frv_mem_checker #(
    parameter int NPAT = 20
) (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                hold_lsu_req,
    input  frv_pkg::s3_op_t     s3_op,
    input  logic                s3_valid,
    input  frv_pkg::fwd_t       fwd,
    input  logic                dmem_req,
    input  frv_pkg::dmem_req_t  dmem,
    input  logic                dmem_gnt,
    input  frv_pkg::wb_t        wb,
    input  logic                wb_valid,
    input  logic                wb_busy,
    input  logic [115:0]        pats [0:NPAT-1],  // Pattern table
    output int                  results,          // Writebacks seen
    output int                  val_errors,       // Wrong values
    output int                  proto_errors      // Handshake faults
);

    import frv_pkg::*;

    logic               prev_req;                 // Last cycle request
    logic               prev_gnt;
    dmem_req_t          prev_dmem;
    logic [115:0]       p;
    logic [115:0]       q;                        // Pattern of the s3 item
    logic [3:0]         kind;
    logic [1:0]         w;
    logic               bad_align;
    logic [31:0]        lane_src;
    int                 k;
    int                 off;
    int                 idx;

    task automatic value_fail(input string msg);
        $display("CHECK FAILED @%0t: %s", $time, msg);
        val_errors++;
    endtask

    task automatic flow_fail(input string msg);
        $display("Protocol error at %0t ns: %s", $time, msg);
        proto_errors++;
    endtask

    // Strobe from width code and low address bits
    function automatic logic [3:0] lane_mask(input logic [1:0] wc, input logic [1:0] a);
        if (wc == `FRV_LSU_BYTE) begin
            return 4'b0001 << a;
        end else if (wc == `FRV_LSU_HALF) begin
            return 4'b0011 << a;
        end
        return 4'b1111;
    endfunction

    function automatic logic misaligned(input logic [1:0] wc, input logic [31:0] a);
        return (wc == `FRV_LSU_HALF && a[0]) || (wc == `FRV_LSU_WORD && a[1:0] != 2'b00);
    endfunction

    initial begin
        results      = 0;
        val_errors   = 0;
        proto_errors = 0;
    end

    always @(posedge g_clk) begin
        if (rst) begin
            prev_req <= 1'b0;
            prev_gnt <= 1'b0;
        end else begin
            // Request protocol ----------------
            if (dmem_req && hold_lsu_req) begin
                flow_fail("request raised while hold_lsu_req is high");
            end
            if (prev_req && !prev_gnt && !hold_lsu_req && !dmem_req) begin
                flow_fail("request dropped before its grant");
            end
            if (prev_req && !prev_gnt && dmem_req && dmem != prev_dmem) begin
                flow_fail("request payload changed before its grant");
            end
            prev_req  <= dmem_req;
            prev_gnt  <= dmem_gnt;
            prev_dmem <= dmem;

            // Granted access vs the s3 pattern
            if (dmem_req && dmem_gnt) begin
                idx  = int'(s3_op.instr);
                q    = pats[idx];
                kind = q[115:112];
                w    = q[109:108];
                off  = int'(q[65:64]);
                if (kind != 4'h1 && kind != 4'h2) begin
                    flow_fail("memory request for a non-memory op");
                end else if (misaligned(w, q[95:64])) begin
                    flow_fail("memory request for a misaligned access");
                end else begin
                    if (dmem.addr != q[95:64]) begin
                        value_fail($sformatf("addr %h, want %h", dmem.addr, q[95:64]));
                    end
                    if (dmem.wen != (kind == 4'h2)) begin
                        value_fail("write enable does not match direction");
                    end
                    if (dmem.strb != lane_mask(w, q[65:64])) begin
                        value_fail($sformatf("strobe %b at addr %h", dmem.strb, dmem.addr));
                    end else if (dmem.wen) begin
                        for (k = 0; k < 4; k++) begin
                            lane_src = q[63:32] >> (8 * (k - off));
                            if (dmem.strb[k] && dmem.wdata[8*k +: 8] != lane_src[7:0]) begin
                                value_fail($sformatf("store lane %0d holds %h", k,
                                                     dmem.wdata[8*k +: 8]));
                            end
                        end
                    end
                end
            end

            // Forwarding from the s3 item
            if (s3_valid) begin
                idx = int'(s3_op.instr);
                q   = pats[idx];
                if (fwd.csr != (q[115:112] == 4'h3) || fwd.rd != q[100:96] ||
                    fwd.wdata != q[95:64] ||
                    fwd.load != (q[115:112] == 4'h1)) begin
                    value_fail("forwarding does not match the s3 item");
                end
            end

            // Writeback in pattern order ------
            if (wb_valid && !wb_busy) begin
                if (results >= NPAT) begin
                    flow_fail("writeback with no pattern left");
                end else begin
                    p         = pats[results];
                    bad_align = (p[115:112] == 4'h1 || p[115:112] == 4'h2) &&
                                misaligned(p[109:108], p[95:64]);
                    if (wb.instr != 32'(results)) begin
                        value_fail($sformatf("result of op %0d, want op %0d", wb.instr, results));
                    end
                    if (wb.rd != p[100:96]) begin
                        value_fail($sformatf("rd %0d, want %0d", wb.rd, p[100:96]));
                    end
                    if (wb.trap != bad_align) begin
                        value_fail($sformatf("trap %b on op %0d", wb.trap, results));
                    end
                    if (!bad_align && wb.wdata != p[31:0]) begin
                        value_fail($sformatf("op %0d wdata %h, want %h",
                                             results, wb.wdata, p[31:0]));
                    end
                end
                results++;
            end
        end
    end

endmodule

//--- design/frv_mem_subsys.sv
// --------------------------------------
// Memory subsystem top
// s3 memory stage, s3/s4 register and s4
// response stage; at most 3 ops in flight
// --------------------------------------
`timescale 1ns/10ps

module frv_mem_subsys (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                flush,        // Empty the s4 register
    input  logic                hold_lsu_req,
    input  frv_pkg::s3_op_t     s3_op,
    input  logic                s3_valid,
    output logic                s3_busy,
    output frv_pkg::fwd_t       fwd,
    output logic                dmem_req,
    output frv_pkg::dmem_req_t  dmem,
    input  logic                dmem_gnt,
    input  logic                dmem_recv,
    input  logic [31:0]         dmem_rdata,
    output frv_pkg::wb_t        wb,
    output logic                wb_valid,
    input  logic                wb_busy
);

    import frv_pkg::*;

    localparam int S4_LEN = $bits(s4_op_t);   // 114

    s4_op_t n_s4_op;                          // Into the register
    s4_op_t s4_op;                            // Out of the register
    logic   p_valid;
    logic   p_busy;
    logic   s4_valid;
    logic   s4_busy;

    frv_pipeline_memory u_mem (
        .g_clk        (g_clk),
        .rst          (rst),
        .hold_lsu_req (hold_lsu_req),
        .s3_op        (s3_op),
        .s3_valid     (s3_valid),
        .s3_busy      (s3_busy),
        .p_busy       (p_busy),
        .p_valid      (p_valid),
        .n_s4_op      (n_s4_op),
        .fwd          (fwd),
        .dmem_req     (dmem_req),
        .dmem         (dmem),
        .dmem_gnt     (dmem_gnt)
    );

    frv_pipeline_register #(.RLEN(S4_LEN)) u_s4_reg (
        .g_clk   (g_clk),
        .rst     (rst),
        .flush   (flush),
        .i_data  (n_s4_op),
        .i_valid (p_valid),
        .o_busy  (p_busy),
        .o_data  (s4_op),
        .o_valid (s4_valid),
        .i_busy  (s4_busy)
    );

    frv_load_response u_resp (
        .g_clk      (g_clk),
        .rst        (rst),
        .s4_op      (s4_op),
        .s4_valid   (s4_valid),
        .s4_busy    (s4_busy),
        .dmem_recv  (dmem_recv),
        .dmem_rdata (dmem_rdata),
        .wb         (wb),
        .wb_valid   (wb_valid),
        .wb_busy    (wb_busy)
    );

endmodule

//--- design/frv_load_response.sv
// --------------------------------------
// Response stage (s4)
// Untrapped memory ops wait for dmem_recv;
// a response during wb back-pressure is
// buffered until the wb register drains
// --------------------------------------
`timescale 1ns/10ps
`include "frv_consts.svh"

module frv_load_response (
    input  logic                  g_clk,
    input  logic                  rst,
    input  frv_pkg::s4_op_t       s4_op,
    input  logic                  s4_valid,
    output logic                  s4_busy,
    input  logic                  dmem_recv,    // One pulse per granted op
    input  logic [`FRV_XLEN-1:0]  dmem_rdata,
    output frv_pkg::wb_t          wb,
    output logic                  wb_valid,
    input  logic                  wb_busy
);

    import frv_pkg::*;

    logic                 fu_lsu;
    logic                 mem_op;               // Needs a response
    logic                 got_resp;             // Response buffered
    logic                 resp_ok;
    logic                 wb_stall;
    logic                 wb_load;              // Move s4 into wb
    logic [`FRV_XLEN-1:0] rdata_q;
    logic [`FRV_XLEN-1:0] rdata_sel;
    logic [`FRV_XLEN-1:0] shifted;
    logic [`FRV_XLEN-1:0] load_data;
    logic [1:0]           byte_off;
    logic                 sgn;
    wb_t                  wb_next;

    // Flow control -----------------------
    assign fu_lsu   = s4_op.fu[`FRV_FU_LSU];
    assign mem_op   = s4_valid && fu_lsu && !s4_op.trap;
    assign resp_ok  = !mem_op || got_resp || dmem_recv;
    assign wb_stall = wb_valid && wb_busy;
    assign wb_load  = s4_valid && resp_ok && !wb_stall;
    assign s4_busy  = s4_valid && !wb_load;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            got_resp <= 1'b0;
        end else if (wb_load) begin
            got_resp <= 1'b0;
        end else if (dmem_recv && mem_op) begin
            got_resp <= 1'b1;                   // wb still busy
        end
    end

    always_ff @(posedge g_clk) begin
        if (dmem_recv) begin
            rdata_q <= dmem_rdata;
        end
    end

    assign rdata_sel = got_resp ? rdata_q : dmem_rdata;

    // Lane select and extension ----------
    always_comb begin
        if (s4_op.opr_a.lsu.strb[0]) begin
            byte_off = 2'd0;
        end else if (s4_op.opr_a.lsu.strb[1]) begin
            byte_off = 2'd1;
        end else if (s4_op.opr_a.lsu.strb[2]) begin
            byte_off = 2'd2;
        end else begin
            byte_off = 2'd3;
        end
    end

    assign shifted = rdata_sel >> {byte_off, 3'b000};
    assign sgn     = s4_op.uop[`FRV_LSU_SIGNED];

    always_comb begin
        case (s4_op.uop[2:1])
            `FRV_LSU_BYTE: load_data = {{24{sgn && shifted[7]}}, shifted[7:0]};
            `FRV_LSU_HALF: load_data = {{16{sgn && shifted[15]}}, shifted[15:0]};
            default:       load_data = rdata_sel;
        endcase
    end

    always_comb begin
        wb_next.rd    = s4_op.rd;
        wb_next.trap  = s4_op.trap;
        wb_next.instr = s4_op.instr;
        if (fu_lsu) begin
            wb_next.wdata = (s4_op.uop[`FRV_LSU_LOAD] && !s4_op.trap) ? load_data : '0;
        end else begin
            wb_next.wdata = s4_op.opr_a.word;   // Non-memory result
        end
    end

    // Writeback register -----------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (!wb_stall) begin
            wb_valid <= wb_load;
        end
    end

    always_ff @(posedge g_clk) begin
        if (wb_load) begin
            wb <= wb_next;
        end
    end

endmodule

//--- design/frv_pipeline_memory.sv
// --------------------------------------
// Memory stage (s3)
// Memory ops stall until granted; trapped
// ops pass through with no request
// Forwarding reflects the current s3 item
// --------------------------------------
`timescale 1ns/10ps
`include "frv_consts.svh"

module frv_pipeline_memory (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                hold_lsu_req,
    input  frv_pkg::s3_op_t     s3_op,
    input  logic                s3_valid,
    output logic                s3_busy,
    input  logic                p_busy,       // Pipeline register full
    output logic                p_valid,      // Load the register
    output frv_pkg::s4_op_t     n_s4_op,      // Next s4 payload
    output frv_pkg::fwd_t       fwd,
    output logic                dmem_req,
    output frv_pkg::dmem_req_t  dmem,
    input  logic                dmem_gnt
);

    logic fu_lsu;                             // Memory op
    logic fu_csr;
    logic lsu_valid;
    logic lsu_ready;
    logic lsu_a_error;
    logic pipe_prog;                          // s3 item accepted

    // Stall control ----------------------
    assign fu_lsu    = s3_op.fu[`FRV_FU_LSU];
    assign fu_csr    = s3_op.fu[`FRV_FU_CSR];
    assign lsu_valid = s3_valid && fu_lsu && !s3_op.trap;

    assign s3_busy   = p_busy || (lsu_valid && !lsu_ready);
    assign p_valid   = s3_valid && !s3_busy;
    assign pipe_prog = p_valid;

    // Load/store unit --------------------
    frv_lsu u_lsu (
        .g_clk        (g_clk),
        .rst          (rst),
        .lsu_valid    (lsu_valid),
        .pipe_prog    (pipe_prog),
        .hold_lsu_req (hold_lsu_req),
        .lsu_op       (s3_op),
        .dmem_gnt     (dmem_gnt),
        .lsu_ready    (lsu_ready),
        .lsu_a_error  (lsu_a_error),
        .dmem_req     (dmem_req),
        .dmem         (dmem)
    );

    // Next s4 payload --------------------
    always_comb begin
        n_s4_op.rd    = s3_op.rd;
        n_s4_op.uop   = s3_op.uop;
        n_s4_op.fu    = s3_op.fu;
        n_s4_op.trap  = s3_op.trap || lsu_a_error;   // Misaligned traps here
        n_s4_op.size  = s3_op.size;
        n_s4_op.instr = s3_op.instr;
        if (fu_lsu) begin
            n_s4_op.opr_a.lsu.pad  = '0;
            n_s4_op.opr_a.lsu.strb = dmem.strb;      // Lane select for s4
            n_s4_op.opr_b          = s3_op.opr_a;    // Access address
        end else begin
            n_s4_op.opr_a.word     = s3_op.opr_a;
            n_s4_op.opr_b          = s3_op.opr_b;
        end
    end

    // Forwarding -------------------------
    assign fwd.rd    = s3_op.rd;
    assign fwd.wdata = s3_op.opr_a;
    assign fwd.load  = s3_valid && fu_lsu && s3_op.uop[`FRV_LSU_LOAD];
    assign fwd.csr   = s3_valid && fu_csr;

endmodule

//--- design/frv_lsu.sv
// --------------------------------------
// Load/store request unit
// One granted request per op; misaligned
// half/word accesses never reach memory
// Request drops while hold_lsu_req is high
// --------------------------------------
`timescale 1ns/10ps
`include "frv_consts.svh"

module frv_lsu (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                lsu_valid,    // Untrapped memory op in s3
    input  logic                pipe_prog,    // s3 item accepted
    input  logic                hold_lsu_req, // Suppress requests
    input  frv_pkg::s3_op_t     lsu_op,
    input  logic                dmem_gnt,
    output logic                lsu_ready,    // Op may leave s3
    output logic                lsu_a_error,  // Misaligned access
    output logic                dmem_req,
    output frv_pkg::dmem_req_t  dmem
);

    logic [`FRV_XLEN-1:0] addr;               // Byte address
    logic [`FRV_XLEN-1:0] sdata;              // Raw store data
    logic [1:0]           width;              // uop[2:1]
    logic                 is_byte;
    logic                 is_half;
    logic                 is_word;
    logic                 done;               // Already granted
    logic [3:0]           strb;

    // Decode -----------------------------
    assign addr    = lsu_op.opr_a;
    assign sdata   = lsu_op.opr_b;
    assign width   = lsu_op.uop[2:1];
    assign is_byte = (width == `FRV_LSU_BYTE);
    assign is_half = (width == `FRV_LSU_HALF);
    assign is_word = (width == `FRV_LSU_WORD);

    assign lsu_a_error = lsu_valid &&
                         ((is_half && addr[0]) || (is_word && |addr[1:0]));

    // Request handshake ------------------
    assign dmem_req  = lsu_valid && !lsu_a_error && !done && !hold_lsu_req;
    assign lsu_ready = lsu_valid && (lsu_a_error || done || (dmem_req && dmem_gnt));

    always_ff @(posedge g_clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (pipe_prog) begin
            done <= 1'b0;                     // Next op starts fresh
        end else if (dmem_req && dmem_gnt) begin
            done <= 1'b1;                     // Granted, s3 still stalled
        end
    end

    // Strobe and lane placement ----------
    always_comb begin
        if (is_byte) begin
            strb = 4'b0001 << addr[1:0];
        end else if (is_half) begin
            strb = 4'b0011 << addr[1:0];
        end else begin
            strb = 4'b1111;                   // Word or unknown width
        end
    end

    always_comb begin
        dmem.wen  = lsu_op.uop[`FRV_LSU_STORE];
        dmem.strb = strb;
        dmem.addr = addr;
        if (is_byte) begin
            dmem.wdata = {4{sdata[7:0]}};     // Every lane
        end else if (is_half) begin
            dmem.wdata = {2{sdata[15:0]}};
        end else begin
            dmem.wdata = sdata;
        end
    end

endmodule

//--- design/frv_pipeline_register.sv
// --------------------------------------
// One-entry valid/busy pipeline register
// Flush drops the held item next cycle
// No bypass, so one bubble-free slot only
// --------------------------------------
`timescale 1ns/10ps

module frv_pipeline_register #(
    parameter int RLEN = 114                 // Payload width
) (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            flush,           // Empty the register
    input  logic [RLEN-1:0] i_data,          // From stage N
    input  logic            i_valid,
    output logic            o_busy,          // Back to stage N
    output logic [RLEN-1:0] o_data,          // To stage N+1
    output logic            o_valid,
    input  logic            i_busy           // From stage N+1
);

    logic load;                              // Take a new item

    // Busy only while full and not draining
    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    // Control ----------------------------
    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;              // Drain or refill
        end
    end

    // Payload ----------------------------
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

//--- design/frv_pkg.sv
// --------------------------------------
// Shared types of the memory subsystem
// s4 operand A is a union: operand word or
// byte strobe of a memory operation
// --------------------------------------
`include "frv_consts.svh"

package frv_pkg;

    // Stage 3 operation, 114 bits
    typedef struct packed {
        logic [4:0]           rd;        // Destination register
        logic [`FRV_XLEN-1:0] opr_a;     // Address for memory ops
        logic [`FRV_XLEN-1:0] opr_b;     // Store data for memory ops
        logic [4:0]           uop;       // Micro-op
        logic [4:0]           fu;        // Functional unit one-hot
        logic                 trap;      // Earlier trap
        logic [1:0]           size;      // Instruction size
        logic [31:0]          instr;     // Instruction word
    } s3_op_t;

    // Operand A seen as the strobe of an access
    typedef struct packed {
        logic [`FRV_XLEN-5:0] pad;       // Always zero
        logic [3:0]           strb;      // Byte lanes of the access
    } s4_lsu_opr_t;

    typedef union packed {
        logic [`FRV_XLEN-1:0] word;      // Pass-through operand
        s4_lsu_opr_t          lsu;       // Memory op view
    } s4_opr_a_u;

    // Stage 4 operation, opr_b is the address for memory ops
    typedef struct packed {
        logic [4:0]           rd;
        s4_opr_a_u            opr_a;
        logic [`FRV_XLEN-1:0] opr_b;
        logic [4:0]           uop;
        logic [4:0]           fu;
        logic                 trap;      // Includes alignment error
        logic [1:0]           size;
        logic [31:0]          instr;
    } s4_op_t;

    typedef struct packed {
        logic                 wen;       // Store
        logic [3:0]           strb;      // Byte enables
        logic [`FRV_XLEN-1:0] wdata;     // Lane-replicated data
        logic [`FRV_XLEN-1:0] addr;      // Byte address
    } dmem_req_t;

    typedef struct packed {
        logic [4:0]           rd;
        logic [`FRV_XLEN-1:0] wdata;
        logic                 trap;
        logic [31:0]          instr;
    } wb_t;

    typedef struct packed {
        logic [4:0]           rd;        // Stage 3 destination
        logic [`FRV_XLEN-1:0] wdata;     // Stage 3 operand A
        logic                 load;      // Load in stage 3
        logic                 csr;       // CSR op in stage 3
    } fwd_t;

endpackage

//--- design/frv_consts.svh
// --------------------------------------
// Core constants for the memory subsystem
// Functional-unit and micro-op bit positions
// must match the decode stage that feeds s3
// --------------------------------------
`ifndef FRV_CONSTS_SVH
`define FRV_CONSTS_SVH

// Data and address width ---------------
`define FRV_XLEN 32                      // RV32 only

// Functional-unit one-hot (5 bits) -----
`define FRV_FU_LSU 2                     // Load/store unit
`define FRV_FU_CSR 4                     // CSR access

// LSU micro-op bits (5 bits) -----------
`define FRV_LSU_SIGNED 0                 // Sign extend load data
`define FRV_LSU_LOAD   3                 // Load access
`define FRV_LSU_STORE  4                 // Store access

// Width codes in uop[2:1]
`define FRV_LSU_BYTE 2'b01
`define FRV_LSU_HALF 2'b10
`define FRV_LSU_WORD 2'b11

`endif
